/* compile.f */
+incdir+test
verilog/rvv_alu_pkg.sv
verilog/rvv_alu_decode.sv
verilog/rvv_alu_mask_p0.sv
verilog/rvv_alu_mask_p1.sv
verilog/rvv_alu_mask_unit.sv
test/tb_clk_gen.sv
test/tb_rvv_alu_mask.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rvv_alu_mask
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_mask_model.svh */
`ifndef TB_MASK_MODEL_SVH
`define TB_MASK_MODEL_SVH

// reference model of the ROB write data

// mask logicals, vs2 op vs1
function automatic vreg_t model_logical(input funct6_t f6, input vreg_t vs2, input vreg_t vs1);
  case (f6)
    6'b011001: return vs2 & vs1;
    6'b011010: return vs2 | vs1;
    default:   return vs2 ^ vs1;
  endcase
endfunction

function automatic vreg_t counted_mask(input vreg_t vs2, input vreg_t v0, input logic vm);
  return vm ? vs2 : (vs2 & v0);
endfunction

// set bits strictly below pos
function automatic int ones_below(input vreg_t m, input int pos);
  int cnt;
  cnt = 0;
  for (int i = 0; i < pos; i++) begin
    if (m[i]) cnt++;
  end
  return cnt;
endfunction

// element k of register idx is global element idx * n + k
function automatic vreg_t model_viota(input vreg_t m, input eew_e eew, input uop_idx_t idx);
  int    w;
  int    n;
  int    cnt;
  vreg_t res;
  w   = 8 << int'(eew);
  n   = 128 / w;
  res = '0;
  for (int k = 0; k < n; k++) begin
    cnt = ones_below(m, int'(idx) * n + k);
    for (int b = 0; b < w; b++) begin
      res[k*w + b] = cnt[b];
    end
  end
  return res;
endfunction

function automatic vreg_t model_result(input alu_issue_t iss, input logic trap);
  vreg_t m;
  if (trap) return '0;
  m = counted_mask(iss.vs2_data, iss.v0_data, iss.vm);
  case (iss.funct6)
    6'b010000: return vreg_t'(ones_below(m, 128));
    6'b010100: return model_viota(m, iss.vd_eew, iss.uop_index);
    default:   return model_logical(iss.funct6, iss.vs2_data, iss.vs1_data);
  endcase
endfunction

`endif

/* test/tb_rvv_alu_mask.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_alu_mask;
  import rvv_alu_pkg::*;
  `include "tb_mask_model.svh"

  typedef struct packed {
    alu_issue_t issue;
    logic       trap;
  } stim_row_t;

  typedef struct packed {
    rob_idx_t rob_entry;
    vreg_t    w_data;
    logic     trap;
  } expect_t;

  localparam int table_rows     = 24;
  localparam int random_rows    = 40;
  localparam int timeout_cycles = 4 + 2 * (table_rows + random_rows) + 20;

  logic       clk;
  logic       rst_n;
  logic       issue_valid;
  alu_issue_t issue;
  pu2rob_t    result;
  stim_row_t  rows[$];
  expect_t    pending[$];
  int         seed;
  int         cycle_count = 0;

  tb_clk_gen u_clk (.clk(clk));

  rvv_alu_mask_unit DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .result      (result)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) stop_on_error("timeout: run did not finish in time");
  end

  task automatic add_row(input funct6_t f6, input vs1_enc_t enc, input logic vm, input eew_e eew,
                         input uop_idx_t idx, input rob_idx_t rob, input vreg_t vs1,
                         input vreg_t vs2, input vreg_t v0, input logic trap);
    stim_row_t row;
    row.issue = '{f6, enc, vm, eew, idx, rob, vs1, vs2, v0};
    row.trap  = trap;
    rows.push_back(row);
  endtask

  task automatic build_table();
    vreg_t ones;
    vreg_t zero;
    vreg_t pa;
    vreg_t pb;
    vreg_t hl;
    vreg_t up;
    vreg_t lw;
    ones = '1;
    zero = '0;
    pa   = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    pb   = 128'hf0f0_3c3c_aaaa_5555_0ff0_c3c3_9999_6666;
    // bits 63 and 64 straddle the half boundary
    hl   = 128'h0000_0000_0000_0001_8000_0000_0000_0000;
    up   = 128'h8000_0000_0000_0001_0000_0000_0000_0000;
    lw   = 128'h0000_0000_0000_0000_dead_beef_0000_ffff;
    add_row(f6_vmand, 5'd0, 1'b1, EEW8, 2'd0, 3'd0, ones, ones, zero, 1'b0);
    add_row(f6_vmand, 5'd3, 1'b1, EEW8, 2'd0, 3'd1, pa, pb, zero, 1'b0);
    add_row(f6_vmor, 5'd0, 1'b1, EEW16, 2'd0, 3'd2, zero, zero, zero, 1'b0);
    add_row(f6_vmor, 5'd7, 1'b0, EEW32, 2'd1, 3'd3, pa, pb, ones, 1'b0);
    add_row(f6_vmxor, 5'd0, 1'b1, EEW8, 2'd0, 3'd4, ones, pa, zero, 1'b0);
    add_row(f6_vmxor, 5'd1, 1'b1, EEW64, 2'd3, 3'd5, pa, pa, zero, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b1, EEW8, 2'd0, 3'd6, pb, ones, zero, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b1, EEW8, 2'd0, 3'd7, pb, up, zero, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b1, EEW8, 2'd0, 3'd0, pb, lw, zero, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b1, EEW8, 2'd0, 3'd1, pb, hl, zero, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b0, EEW8, 2'd0, 3'd2, pb, ones, pa, 1'b0);
    add_row(f6_vwxunary0, vs1_vcpop, 1'b0, EEW8, 2'd0, 3'd3, pb, pa, pb, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW8, 2'd0, 3'd4, pb, pa, zero, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW16, 2'd0, 3'd5, pb, hl, zero, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW16, 2'd1, 3'd6, pb, ones, zero, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b0, EEW32, 2'd0, 3'd7, pb, pa, pb, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW32, 2'd1, 3'd0, pb, pa, zero, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW32, 2'd2, 3'd1, pb, hl, zero, 1'b0);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW32, 2'd3, 3'd2, pb, ones, zero, 1'b0);
    // unsupported encodings and illegal viota shapes
    add_row(6'b000000, 5'd0, 1'b1, EEW8, 2'd0, 3'd3, pa, pb, zero, 1'b1);
    add_row(f6_vwxunary0, 5'b00001, 1'b1, EEW8, 2'd0, 3'd4, pa, pb, zero, 1'b1);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW64, 2'd0, 3'd5, pa, pb, zero, 1'b1);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW8, 2'd1, 3'd6, pa, pb, zero, 1'b1);
    add_row(f6_vmunary0, vs1_viota, 1'b1, EEW16, 2'd2, 3'd7, pa, pb, zero, 1'b1);
  endtask

  function automatic vreg_t rand_vreg();
    vreg_t v;
    for (int i = 0; i < 4; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  // legal opcodes only, so no trap is expected
  task automatic make_random_rows();
    int          op;
    logic [31:0] r;
    funct6_t     f6;
    vs1_enc_t    enc;
    eew_e        eew;
    uop_idx_t    idx;
    for (int i = 0; i < random_rows; i++) begin
      op  = int'($unsigned($random(seed)) % 5);
      r   = $random(seed);
      enc = (op < 3) ? r[8:4] : 5'b10000;
      eew = eew_e'(r[1:0]);
      idx = r[3:2];
      case (op)
        0: f6 = f6_vmand;
        1: f6 = f6_vmor;
        2: f6 = f6_vmxor;
        3: f6 = f6_vwxunary0;
        default: begin
          f6  = f6_vmunary0;
          eew = eew_e'(r[1:0] % 2'd3);
          case (eew)
            EEW8:    idx = 2'd0;
            EEW16:   idx = {1'b0, r[2]};
            default: idx = r[3:2];
          endcase
        end
      endcase
      add_row(f6, enc, r[9], eew, idx, r[12:10], rand_vreg(), rand_vreg(), rand_vreg(), 1'b0);
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    expect_t e;
    issue       = row.issue;
    issue_valid = 1'b1;
    e.rob_entry = row.issue.rob_entry;
    e.trap      = row.trap;
    e.w_data    = model_result(row.issue, row.trap);
    pending.push_back(e);
  endtask

  task automatic check_result();
    expect_t e;
    if (pending.size() == 0) begin
      assert (result.w_valid === 1'b0)
        else stop_on_error("ROB write seen with no issue outstanding");
    end else begin
      e = pending.pop_front();
      assert (result.w_valid === 1'b1)
        else stop_on_error("expected ROB write did not arrive");
      assert (result.rob_entry === e.rob_entry)
        else stop_on_error($sformatf("mismatch rob_entry: got 0x%h expected 0x%h",
                                     result.rob_entry, e.rob_entry));
      assert (result.trap === e.trap)
        else stop_on_error($sformatf("mismatch trap: got 0x%h expected 0x%h",
                                     result.trap, e.trap));
      assert (result.w_data === e.w_data)
        else stop_on_error($sformatf("mismatch w_data: got 0x%h expected 0x%h",
                                     result.w_data, e.w_data));
    end
  endtask

  initial begin
    seed        = 44512;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    build_table();
    make_random_rows();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      check_result();
      // one idle cycle between fixed and random rows
      if (i == table_rows) begin
        issue_valid = 1'b0;
        @(negedge clk);
        check_result();
      end
      apply_row(rows[i]);
    end
    @(negedge clk);
    check_result();
    issue_valid = 1'b0;
    @(negedge clk);
    check_result();
    if (pending.size() != 0) begin
      stop_on_error("expected ROB write missing at end of run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

`default_nettype wire

/* verilog/rvv_alu_mask_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_mask_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    issue_valid,
  input  rvv_alu_pkg::alu_issue_t issue,
  output rvv_alu_pkg::pu2rob_t    result
);
  import rvv_alu_pkg::*;

  alu_uop_t   uop;
  logic       pipe_valid;
  pipe_data_t pipe;

  rvv_alu_decode u_decode (
    .issue (issue),
    .uop   (uop)
  );

  // one register stage between issue and ROB write
  rvv_alu_mask_p0 u_p0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (issue_valid),
    .uop        (uop),
    .pipe_valid (pipe_valid),
    .pipe       (pipe)
  );

  rvv_alu_mask_p1 u_p1 (
    .alu_uop_valid (pipe_valid),
    .alu_uop       (pipe),
    .result        (result)
  );

endmodule

`default_nettype wire

/* verilog/rvv_alu_mask_p1.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_mask_p1 (
  input  logic                    alu_uop_valid,
  input  rvv_alu_pkg::pipe_data_t alu_uop,
  output rvv_alu_pkg::pu2rob_t    result
);
  import rvv_alu_pkg::*;

  viota_cnt_t [vlen-1:0]          viota_all;
  viota_cnt_t [vlenb-1:0]         viota8;
  viota_cnt_t [vlen/hword_w-1:0]  viota16;
  viota_cnt_t [vlen/word_w-1:0]   viota32;
  xreg_t                          vcpop_cnt;

  // upper half is offset by the lower half total
  for (genvar j = 0; j < half_len; j++) begin : g_join
    assign viota_all[j] = {1'b0, alu_uop.viota_per64[0][j]};
    assign viota_all[j+half_len] = {1'b0, alu_uop.viota_per64[1][j]} +
                                   {1'b0, alu_uop.viota_per64[0][half_len-1]};
  end

  // element pick for the current register of the group
  for (genvar j = 0; j < vlenb; j++) begin : g_sel8
    assign viota8[j] = viota_all[int'(alu_uop.uop_index) * vlenb + j];
  end

  for (genvar j = 0; j < vlen/hword_w; j++) begin : g_sel16
    assign viota16[j] = viota_all[int'(alu_uop.uop_index) * (vlen/hword_w) + j];
  end

  for (genvar j = 0; j < vlen/word_w; j++) begin : g_sel32
    assign viota32[j] = viota_all[int'(alu_uop.uop_index) * (vlen/word_w) + j];
  end

  assign vcpop_cnt = xreg_t'(viota_all[vlen-1]);

  always_comb begin
    result.w_valid   = alu_uop_valid;
    result.rob_entry = alu_uop.rob_entry;
    result.trap      = alu_uop.trap;
    result.w_data    = alu_uop.result_data;
    case (alu_uop.sub_opcode)
      OP_VCPOP: result.w_data = vreg_t'(vcpop_cnt);
      OP_VIOTA: begin
        case (alu_uop.vd_eew)
          EEW8: begin
            for (int i = 0; i < vlenb; i++) begin
              result.w_data[i*byte_w +: byte_w] = viota8[i];
            end
          end
          EEW16: begin
            for (int i = 0; i < vlen/hword_w; i++) begin
              result.w_data[i*hword_w +: hword_w] = hword_w'(viota16[i]);
            end
          end
          EEW32: begin
            for (int i = 0; i < vlen/word_w; i++) begin
              result.w_data[i*word_w +: word_w] = word_w'(viota32[i]);
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // decode must have trapped any index beyond the register group
  always_comb begin
    if (alu_uop_valid && alu_uop.sub_opcode == OP_VIOTA) begin
      assert ((alu_uop.vd_eew != EEW16 || alu_uop.uop_index < 2'd2) &&
              (alu_uop.vd_eew != EEW8 || alu_uop.uop_index == 2'd0))
        else $error("viota uop_index %0d out of range for eew %0d",
                    alu_uop.uop_index, alu_uop.vd_eew);
    end
  end

endmodule

`default_nettype wire

/* verilog/rvv_alu_mask_p0.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_mask_p0 (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  input  rvv_alu_pkg::alu_uop_t   uop,
  output logic                    pipe_valid,
  output rvv_alu_pkg::pipe_data_t pipe
);
  import rvv_alu_pkg::*;

  vreg_t                         logic_res;
  vreg_t                         masked_vs2;
  vreg_t                         count_mask;
  logic                          is_logical;
  half_cnt_t [1:0][half_len-1:0] prefix;
  pipe_data_t                    pipe_d;

  always_comb begin
    case (uop.sub_opcode)
      OP_VMOR:  logic_res = uop.vs2_data | uop.vs1_data;
      OP_VMXOR: logic_res = uop.vs2_data ^ uop.vs1_data;
      default:  logic_res = uop.vs2_data & uop.vs1_data;
    endcase
  end

  assign is_logical = (uop.sub_opcode == OP_VMAND) ||
                      (uop.sub_opcode == OP_VMOR) ||
                      (uop.sub_opcode == OP_VMXOR);

  assign masked_vs2 = uop.vm ? uop.vs2_data : (uop.vs2_data & uop.v0_data);

  // shift by one so the inclusive prefix gives the exclusive viota count
  assign count_mask = (uop.sub_opcode == OP_VIOTA) ?
                      {masked_vs2[vlen-2:0], 1'b0} : masked_vs2;

  // inclusive prefix counts per 64-bit half
  always_comb begin : prefix_count
    half_cnt_t acc;
    for (int h = 0; h < 2; h++) begin
      acc = '0;
      for (int j = 0; j < half_len; j++) begin
        acc = acc + half_cnt_t'(count_mask[h*half_len + j]);
        prefix[h][j] = acc;
      end
    end
  end

  always_comb begin
    pipe_d.sub_opcode  = uop.sub_opcode;
    pipe_d.trap        = uop.trap;
    pipe_d.vd_eew      = uop.vd_eew;
    pipe_d.uop_index   = uop.uop_index;
    pipe_d.rob_entry   = uop.rob_entry;
    pipe_d.result_data = '0;
    if (is_logical && !uop.trap) begin
      pipe_d.result_data = logic_res;
    end
    pipe_d.viota_per64 = prefix;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= uop_valid;
    end
  end

  // payload holds when idle
  always_ff @(posedge clk) begin
    if (uop_valid) begin
      pipe <= pipe_d;
    end
  end

  // a trapped issue lands as a zeroed entry next cycle
  a_trap_zero: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid && uop.trap |=> pipe_valid && pipe.trap && (pipe.result_data == '0))
    else $error("trapped entry carries nonzero result_data");

endmodule

`default_nettype wire

/* verilog/rvv_alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_decode (
  input  rvv_alu_pkg::alu_issue_t issue,
  output rvv_alu_pkg::alu_uop_t   uop
);
  import rvv_alu_pkg::*;

  alu_sub_op_e op;
  logic        known;
  logic        bad_index;
  logic        is_viota;

  // opcode classification
  always_comb begin
    op    = OP_VMAND;
    known = 1'b1;
    case (issue.funct6)
      f6_vmand: op = OP_VMAND;
      f6_vmor:  op = OP_VMOR;
      f6_vmxor: op = OP_VMXOR;
      f6_vwxunary0: begin
        if (issue.vs1_enc == vs1_vcpop) op = OP_VCPOP;
        else known = 1'b0;
      end
      f6_vmunary0: begin
        if (issue.vs1_enc == vs1_viota) op = OP_VIOTA;
        else known = 1'b0;
      end
      default: known = 1'b0;
    endcase
  end

  // destination group is 1, 2 or 4 registers
  always_comb begin
    case (issue.vd_eew)
      EEW8:    bad_index = (issue.uop_index != 2'd0);
      EEW16:   bad_index = issue.uop_index[1];
      EEW32:   bad_index = 1'b0;
      default: bad_index = 1'b1;
    endcase
  end

  assign is_viota = known && (op == OP_VIOTA);

  always_comb begin
    uop.trap       = !known || (is_viota && bad_index);
    uop.sub_opcode = uop.trap ? OP_VMAND : op;
    uop.vm         = issue.vm;
    uop.vd_eew     = issue.vd_eew;
    uop.uop_index  = issue.uop_index;
    uop.rob_entry  = issue.rob_entry;
    uop.vs1_data   = issue.vs1_data;
    uop.vs2_data   = issue.vs2_data;
    uop.v0_data    = issue.v0_data;
  end

  // viota has no 64-bit form here
  always_comb begin
    if (issue.funct6 == f6_vmunary0 && issue.vs1_enc == vs1_viota &&
        issue.vd_eew == EEW64) begin
      assert (uop.trap)
        else $error("viota with EEW64 decoded without trap");
    end
  end

endmodule

`default_nettype wire

/* verilog/rvv_alu_pkg.sv */
`default_nettype none

package rvv_alu_pkg;

  localparam int vlen      = 128;
  localparam int xlen      = 32;
  localparam int vlenb     = vlen / 8;
  localparam int rob_depth = 8;
  localparam int half_len  = vlen / 2;

  // element widths in bits
  localparam int byte_w  = 8;
  localparam int hword_w = 16;
  localparam int word_w  = 32;

  // OPMVV encodings
  localparam logic [5:0] f6_vmand  = 6'b011001;
  localparam logic [5:0] f6_vmor   = 6'b011010;
  localparam logic [5:0] f6_vmxor  = 6'b011011;
  localparam logic [5:0] f6_vwxunary0 = 6'b010000;
  localparam logic [5:0] f6_vmunary0  = 6'b010100;
  localparam logic [4:0] vs1_vcpop = 5'b10000;
  localparam logic [4:0] vs1_viota = 5'b10000;

  typedef logic [vlen-1:0]              vreg_t;
  typedef logic [xlen-1:0]              xreg_t;
  typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
  typedef logic [1:0]                   uop_idx_t;
  typedef logic [7:0]                   viota_cnt_t;
  typedef logic [6:0]                   half_cnt_t;
  typedef logic [5:0]                   funct6_t;
  typedef logic [4:0]                   vs1_enc_t;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2,
    EEW64 = 2'd3
  } eew_e;

  typedef enum logic [2:0] {
    OP_VMAND = 3'd0,
    OP_VMOR  = 3'd1,
    OP_VMXOR = 3'd2,
    OP_VCPOP = 3'd3,
    OP_VIOTA = 3'd4
  } alu_sub_op_e;

  typedef struct packed {
    funct6_t  funct6;
    vs1_enc_t vs1_enc;
    logic     vm;
    eew_e     vd_eew;
    uop_idx_t uop_index;
    rob_idx_t rob_entry;
    vreg_t    vs1_data;
    vreg_t    vs2_data;
    vreg_t    v0_data;
  } alu_issue_t;

  typedef struct packed {
    alu_sub_op_e sub_opcode;
    logic        trap;
    logic        vm;
    eew_e        vd_eew;
    uop_idx_t    uop_index;
    rob_idx_t    rob_entry;
    vreg_t       vs1_data;
    vreg_t       vs2_data;
    vreg_t       v0_data;
  } alu_uop_t;

  typedef struct packed {
    alu_sub_op_e                      sub_opcode;
    logic                             trap;
    eew_e                             vd_eew;
    uop_idx_t                         uop_index;
    rob_idx_t                         rob_entry;
    vreg_t                            result_data;
    half_cnt_t [1:0][half_len-1:0]    viota_per64;
  } pipe_data_t;

  typedef struct packed {
    logic     w_valid;
    rob_idx_t rob_entry;
    vreg_t    w_data;
    logic     trap;
  } pu2rob_t;

endpackage

`default_nettype wire
